//--- all.f
hw/lattice_pkg.sv
hw/control_pkg.sv
hw/lattice_bank.sv
hw/neighbor_addr.sv
hw/step_sequencer.sv
hw/lbm_core.sv
tb/tb_lbm_core.sv

//--- hw/control_pkg.sv
`default_nettype none

package control_pkg;

    // Phases of one time step, plus idle for host access
    typedef enum logic [1:0] {
        idle   = 2'd0,
        stream = 2'd1,
        bounce = 2'd2,
        zero   = 2'd3
    } seq_state_t;

    // Number of time steps requested or left
    typedef logic [15:0] step_count_t;

endpackage

`default_nettype wire

//--- hw/lattice_bank.sv
`timescale 1ns/1ps
`default_nettype none

module lattice_bank #(
    parameter int grid_width  = 6,
    parameter int grid_height = 4
) (
    input  logic                    clk,
    input  logic                    rd_bank,
    input  lattice_pkg::cell_addr_t rd_addr,
    output lattice_pkg::dist_t      rd_data [lattice_pkg::num_dirs],
    input  logic                    wr_bank,
    input  logic [lattice_pkg::num_dirs-1:0] wr_en,
    input  lattice_pkg::cell_addr_t wr_addr [lattice_pkg::num_dirs],
    input  lattice_pkg::dist_t      wr_data [lattice_pkg::num_dirs]
);

    localparam int depth = grid_width * grid_height;
    localparam int idx_w = (depth > 1) ? $clog2(depth) : 1;

    ////////////////////////////////////////////////////////////////////
    // One pair of arrays per direction

    for (genvar d = 0; d < lattice_pkg::num_dirs; d++)
    begin : g_dir
        lattice_pkg::dist_t bank0 [depth];
        lattice_pkg::dist_t bank1 [depth];
        logic [idx_w-1:0]   rd_idx;
        logic [idx_w-1:0]   wr_idx;

        assign rd_idx = rd_addr[idx_w-1:0];
        assign wr_idx = wr_addr[d][idx_w-1:0];

        // Each direction writes its own word, independent of the others
        always_ff @(posedge clk)
        begin
            if (wr_en[d] && !wr_bank)
            begin
                bank0[wr_idx] <= wr_data[d];
            end
            if (wr_en[d] && wr_bank)
            begin
                bank1[wr_idx] <= wr_data[d];
            end
        end

        // Registered read, old value on a same-word write
        always_ff @(posedge clk)
        begin
            if (rd_bank)
            begin
                rd_data[d] <= bank1[rd_idx];
            end
            else
            begin
                rd_data[d] <= bank0[rd_idx];
            end
        end

        // Sequencer and neighbour logic must never aim past the grid
        a_wr_addr_in_grid: assert property (@(posedge clk)
            wr_en[d] |-> (int'(wr_addr[d]) < depth))
            else $error("lattice_bank: dir %0d write to cell %0d", d, wr_addr[d]);
    end

endmodule

`default_nettype wire

//--- hw/lattice_pkg.sv
`default_nettype none

package lattice_pkg;

    // One distribution value per direction per cell
    typedef logic [15:0] dist_t;

    // Linear cell index, row * grid_width + column
    typedef logic [7:0] cell_addr_t;

    // D2Q9 directions, north is row - 1 and east is column + 1
    typedef enum logic [3:0] {
        dir_rest = 4'd0,
        dir_n    = 4'd1,
        dir_ne   = 4'd2,
        dir_e    = 4'd3,
        dir_se   = 4'd4,
        dir_s    = 4'd5,
        dir_sw   = 4'd6,
        dir_w    = 4'd7,
        dir_nw   = 4'd8
    } dir_t;

    localparam int num_dirs = 9;

    ////////////////////////////////////////////////////////////////////
    // Direction helpers

    function automatic dir_t dir_opposite(dir_t d);
        case (d)
            dir_n:   return dir_s;
            dir_ne:  return dir_sw;
            dir_e:   return dir_w;
            dir_se:  return dir_nw;
            dir_s:   return dir_n;
            dir_sw:  return dir_ne;
            dir_w:   return dir_e;
            dir_nw:  return dir_se;
            default: return dir_rest;
        endcase
    endfunction

    // Row offset of one move
    function automatic int dir_drow(dir_t d);
        case (d)
            dir_n, dir_ne, dir_nw: return -1;
            dir_s, dir_se, dir_sw: return 1;
            default:               return 0;
        endcase
    endfunction

    // Column offset of one move
    function automatic int dir_dcol(dir_t d);
        case (d)
            dir_ne, dir_e, dir_se: return 1;
            dir_sw, dir_w, dir_nw: return -1;
            default:               return 0;
        endcase
    endfunction

endpackage

`default_nettype wire

//--- hw/lbm_core.sv
`timescale 1ns/1ps
`default_nettype none

module lbm_core #(
    parameter int grid_width  = 6,
    parameter int grid_height = 4
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              start,
    input  control_pkg::step_count_t          steps,
    input  logic [grid_width*grid_height-1:0] barriers,
    output logic                              busy,
    output logic                              done,
    input  logic                              host_wr_en,
    input  logic                              host_rd_en,
    input  lattice_pkg::cell_addr_t           host_addr,
    input  lattice_pkg::dir_t                 host_dir,
    input  lattice_pkg::dist_t                host_wdata,
    output lattice_pkg::dist_t                host_rdata,
    output logic                              host_rvalid
);

    // Sequencer to neighbour logic
    lattice_pkg::cell_addr_t          scan_cell;
    lattice_pkg::cell_addr_t          nbr_addr [lattice_pkg::num_dirs];
    logic [lattice_pkg::num_dirs-1:0] nbr_valid;

    // Sequencer to memory
    logic                             rd_bank;
    lattice_pkg::cell_addr_t          rd_addr;
    lattice_pkg::dist_t               rd_data [lattice_pkg::num_dirs];
    logic                             wr_bank;
    logic [lattice_pkg::num_dirs-1:0] wr_en;
    lattice_pkg::cell_addr_t          wr_addr [lattice_pkg::num_dirs];
    lattice_pkg::dist_t               wr_data [lattice_pkg::num_dirs];

    step_sequencer #(
        .grid_width  (grid_width),
        .grid_height (grid_height)
    ) u_step_sequencer (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .steps       (steps),
        .barriers    (barriers),
        .busy        (busy),
        .done        (done),
        .host_wr_en  (host_wr_en),
        .host_rd_en  (host_rd_en),
        .host_addr   (host_addr),
        .host_dir    (host_dir),
        .host_wdata  (host_wdata),
        .host_rdata  (host_rdata),
        .host_rvalid (host_rvalid),
        .scan_cell   (scan_cell),
        .nbr_addr    (nbr_addr),
        .nbr_valid   (nbr_valid),
        .rd_bank     (rd_bank),
        .rd_addr     (rd_addr),
        .rd_data     (rd_data),
        .wr_bank     (wr_bank),
        .wr_en       (wr_en),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data)
    );

    neighbor_addr #(
        .grid_width  (grid_width),
        .grid_height (grid_height)
    ) u_neighbor_addr (
        .scan_cell (scan_cell),
        .nbr_addr  (nbr_addr),
        .nbr_valid (nbr_valid)
    );

    lattice_bank #(
        .grid_width  (grid_width),
        .grid_height (grid_height)
    ) u_lattice_bank (
        .clk     (clk),
        .rd_bank (rd_bank),
        .rd_addr (rd_addr),
        .rd_data (rd_data),
        .wr_bank (wr_bank),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data)
    );

endmodule

`default_nettype wire

//--- hw/neighbor_addr.sv
`timescale 1ns/1ps
`default_nettype none

module neighbor_addr #(
    parameter int grid_width  = 6,
    parameter int grid_height = 4
) (
    input  lattice_pkg::cell_addr_t          scan_cell,
    output lattice_pkg::cell_addr_t          nbr_addr [lattice_pkg::num_dirs],
    output logic [lattice_pkg::num_dirs-1:0] nbr_valid
);

    ////////////////////////////////////////////////////////////////////
    // Row and column split followed by one move per direction

    always_comb
    begin
        int row;
        int col;
        int nrow;
        int ncol;
        lattice_pkg::dir_t dir;

        row = int'(scan_cell) / grid_width;
        col = int'(scan_cell) % grid_width;

        for (int d = 0; d < lattice_pkg::num_dirs; d++)
        begin
            dir  = lattice_pkg::dir_t'(d);
            nrow = row + lattice_pkg::dir_drow(dir);
            ncol = col + lattice_pkg::dir_dcol(dir);

            // No wrap-around on any edge
            nbr_valid[d] = (nrow >= 0) && (nrow < grid_height) &&
                           (ncol >= 0) && (ncol < grid_width);

            if (nbr_valid[d])
            begin
                nbr_addr[d] = lattice_pkg::cell_addr_t'(nrow * grid_width + ncol);
            end
            else
            begin
                nbr_addr[d] = scan_cell;
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/step_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module step_sequencer #(
    parameter int grid_width  = 6,
    parameter int grid_height = 4
) (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             start,
    input  control_pkg::step_count_t         steps,
    input  logic [grid_width*grid_height-1:0] barriers,
    output logic                             busy,
    output logic                             done,
    input  logic                             host_wr_en,
    input  logic                             host_rd_en,
    input  lattice_pkg::cell_addr_t          host_addr,
    input  lattice_pkg::dir_t                host_dir,
    input  lattice_pkg::dist_t               host_wdata,
    output lattice_pkg::dist_t               host_rdata,
    output logic                             host_rvalid,
    output lattice_pkg::cell_addr_t          scan_cell,
    input  lattice_pkg::cell_addr_t          nbr_addr [lattice_pkg::num_dirs],
    input  logic [lattice_pkg::num_dirs-1:0] nbr_valid,
    output logic                             rd_bank,
    output lattice_pkg::cell_addr_t          rd_addr,
    input  lattice_pkg::dist_t               rd_data [lattice_pkg::num_dirs],
    output logic                             wr_bank,
    output logic [lattice_pkg::num_dirs-1:0] wr_en,
    output lattice_pkg::cell_addr_t          wr_addr [lattice_pkg::num_dirs],
    output lattice_pkg::dist_t               wr_data [lattice_pkg::num_dirs]
);

    localparam int depth = grid_width * grid_height;
    localparam int idx_w = (depth > 1) ? $clog2(depth) : 1;
    localparam lattice_pkg::cell_addr_t last_cell = lattice_pkg::cell_addr_t'(depth - 1);

    control_pkg::seq_state_t  state;
    control_pkg::step_count_t steps_left;
    lattice_pkg::cell_addr_t  scan_idx;
    lattice_pkg::dir_t        host_dir_q;
    logic                     issue;
    logic                     arr_valid;
    logic                     cur_bank;
    logic                     arr_barrier;

    ////////////////////////////////////////////////////////////////////
    // Phase FSM and cell scan

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            state       <= control_pkg::idle;
            steps_left  <= '0;
            scan_idx    <= '0;
            scan_cell   <= '0;
            issue       <= 1'b0;
            arr_valid   <= 1'b0;
            cur_bank    <= 1'b0;
            done        <= 1'b0;
            host_rvalid <= 1'b0;
        end
        else
        begin
            done        <= 1'b0;
            host_rvalid <= (state == control_pkg::idle) && host_rd_en;
            // Read data of scan_idx arrives one cycle later as scan_cell
            arr_valid   <= issue;
            scan_cell   <= scan_idx;

            case (state)
                control_pkg::idle:
                begin
                    if (start && (steps != '0))
                    begin
                        state      <= control_pkg::stream;
                        steps_left <= steps;
                        scan_idx   <= '0;
                        issue      <= 1'b1;
                    end
                end
                control_pkg::stream, control_pkg::bounce:
                begin
                    if (issue)
                    begin
                        scan_idx <= scan_idx + 1'b1;
                        issue    <= (scan_idx != last_cell);
                    end
                    // Phase ends when the last cell's data has been used
                    if (arr_valid && (scan_cell == last_cell))
                    begin
                        scan_idx <= '0;
                        if (state == control_pkg::stream)
                        begin
                            state <= control_pkg::bounce;
                            issue <= 1'b1;
                        end
                        else
                        begin
                            state <= control_pkg::zero;
                            issue <= 1'b0;
                        end
                    end
                end
                control_pkg::zero:
                begin
                    if (scan_idx == last_cell)
                    begin
                        // Next bank becomes current
                        cur_bank   <= !cur_bank;
                        steps_left <= steps_left - 1'b1;
                        scan_idx   <= '0;
                        if (steps_left == control_pkg::step_count_t'(1))
                        begin
                            state <= control_pkg::idle;
                            done  <= 1'b1;
                        end
                        else
                        begin
                            state <= control_pkg::stream;
                            issue <= 1'b1;
                        end
                    end
                    else
                    begin
                        scan_idx <= scan_idx + 1'b1;
                    end
                end
                default:
                begin
                    state <= control_pkg::idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        host_dir_q <= host_dir;
    end

    assign busy       = (state != control_pkg::idle);
    assign host_rdata = rd_data[host_dir_q];

    ////////////////////////////////////////////////////////////////////
    // Memory port control

    // Bounce works on the values that stream left in the next bank
    assign rd_bank     = (state == control_pkg::bounce) ? !cur_bank : cur_bank;
    assign rd_addr     = (state == control_pkg::idle) ? host_addr : scan_idx;
    assign wr_bank     = (state == control_pkg::idle) ? cur_bank : !cur_bank;
    assign arr_barrier = barriers[scan_cell[idx_w-1:0]];

    always_comb
    begin
        lattice_pkg::dir_t opp;

        for (int d = 0; d < lattice_pkg::num_dirs; d++)
        begin
            opp        = lattice_pkg::dir_opposite(lattice_pkg::dir_t'(d));
            wr_en[d]   = 1'b0;
            wr_addr[d] = nbr_addr[d];
            wr_data[d] = rd_data[d];

            case (state)
                control_pkg::idle:
                begin
                    wr_en[d]   = host_wr_en && (int'(host_dir) == d);
                    wr_addr[d] = host_addr;
                    wr_data[d] = host_wdata;
                end
                control_pkg::stream:
                begin
                    // Fluid cells push every direction to its neighbour
                    wr_en[d] = arr_valid && !arr_barrier && nbr_valid[d];
                end
                control_pkg::bounce:
                begin
                    wr_data[d] = rd_data[opp];
                    wr_en[d]   = arr_valid && arr_barrier && nbr_valid[d] &&
                                 !barriers[nbr_addr[d][idx_w-1:0]];
                end
                default:
                begin
                    wr_addr[d] = scan_idx;
                    wr_data[d] = '0;
                    wr_en[d]   = barriers[scan_idx[idx_w-1:0]];
                end
            endcase
        end
    end

    a_no_host_while_busy: assert property (@(posedge clk) disable iff (!rst)
        busy |-> !(host_wr_en || host_rd_en))
        else $error("step_sequencer: host access while busy");

    // No scan read or write is still in flight once the FSM is idle
    a_idle_pipe_empty: assert property (@(posedge clk) disable iff (!rst)
        !busy |-> !(issue || arr_valid))
        else $error("step_sequencer: scan pipeline active in idle");

endmodule

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f all.f --top-module tb_lbm_core -Mdir obj_dir -o sim_lbm_core
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_lbm_core 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "Finished with no errors" <<< "$output"; then
    exit 0
fi
exit 1

//--- tb/tb_lbm_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_lbm_core;

    localparam int grid_width  = 6;
    localparam int grid_height = 4;
    localparam int cells       = grid_width * grid_height;
    localparam int words       = cells * lattice_pkg::num_dirs;
    localparam int step_cycles = 3 * cells + 2;
    localparam int num_rows    = 5;

    typedef struct packed {
        logic [cells-1:0]         mask;
        control_pkg::step_count_t steps;
        logic                     load;
    } table_row_t;

    // Barrier mask, step count, grid load before the run
    localparam table_row_t stim_table [num_rows] = '{
        '{24'hff_ffff, 16'd1, 1'b1},   // all barrier, clears the second bank
        '{24'h00_0000, 16'd1, 1'b1},
        '{24'h00_c300, 16'd1, 1'b1},   // 2x2 block in the middle
        '{24'h30_2421, 16'd5, 1'b1},
        '{24'h08_1240, 16'd3, 1'b0}
    };

    // Row and column offset per direction, north is row - 1
    localparam int move_row [lattice_pkg::num_dirs] = '{0, -1, -1, 0, 1, 1, 1, 0, -1};
    localparam int move_col [lattice_pkg::num_dirs] = '{0, 0, 1, 1, 1, 0, -1, -1, -1};

    logic                     clk;
    logic                     rst;
    logic                     start;
    control_pkg::step_count_t steps;
    logic [cells-1:0]         barriers;
    logic                     busy;
    logic                     done;
    logic                     host_wr_en;
    logic                     host_rd_en;
    lattice_pkg::cell_addr_t  host_addr;
    lattice_pkg::dir_t        host_dir;
    lattice_pkg::dist_t       host_wdata;
    lattice_pkg::dist_t       host_rdata;
    logic                     host_rvalid;

    // Reference lattice, both banks
    lattice_pkg::dist_t model_bank [2][lattice_pkg::num_dirs][cells];
    int                 model_cur = 0;
    logic [31:0]        lfsr_state = 32'hb41ae7fc;

    lbm_core #(
        .grid_width  (grid_width),
        .grid_height (grid_height)
    ) u_dut (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .steps       (steps),
        .barriers    (barriers),
        .busy        (busy),
        .done        (done),
        .host_wr_en  (host_wr_en),
        .host_rd_en  (host_rd_en),
        .host_addr   (host_addr),
        .host_dir    (host_dir),
        .host_wdata  (host_wdata),
        .host_rdata  (host_rdata),
        .host_rvalid (host_rvalid)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////
    // Compare tasks

    task automatic check_dist(string name, lattice_pkg::dist_t got, lattice_pkg::dist_t exp);
        if (got !== exp)
        begin
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
            $display("Finished with errors");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic check_flag(string name, logic got, logic exp);
        if (got !== exp)
        begin
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
            $display("Finished with errors");
            $fatal(1, "flag mismatch");
        end
    endtask

    ////////////////////////////////////////////////////////////////////
    // Stimulus values and reference model

    function automatic logic [31:0] lfsr_shift(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // 16 LFSR steps, one per bit
    task automatic draw_dist(output lattice_pkg::dist_t v);
        v = '0;
        for (int i = 0; i < 16; i++)
        begin
            lfsr_state = lfsr_shift(lfsr_state);
            v = {v[14:0], lfsr_state[0]};
        end
    endtask

    function automatic int reverse_dir(int d);
        for (int e = 0; e < lattice_pkg::num_dirs; e++)
        begin
            if (move_row[e] == -move_row[d] && move_col[e] == -move_col[d])
            begin
                return e;
            end
        end
        return 0;
    endfunction

    // Target cell of one move, -1 off the grid
    function automatic int move_target(int c, int d);
        int r;
        int col;
        r   = c / grid_width + move_row[d];
        col = c % grid_width + move_col[d];
        if (r < 0 || r >= grid_height || col < 0 || col >= grid_width)
        begin
            return -1;
        end
        return r * grid_width + col;
    endfunction

    task automatic model_run(logic [cells-1:0] mask, int n);
        int nxt;
        int t;
        for (int s = 0; s < n; s++)
        begin
            nxt = 1 - model_cur;
            // Stream out of fluid cells
            for (int c = 0; c < cells; c++)
            begin
                for (int d = 0; d < lattice_pkg::num_dirs; d++)
                begin
                    t = move_target(c, d);
                    if (!mask[c] && t >= 0)
                    begin
                        model_bank[nxt][d][t] = model_bank[model_cur][d][c];
                    end
                end
            end
            // Barriers send arrived values back to fluid neighbours
            for (int c = 0; c < cells; c++)
            begin
                for (int d = 0; d < lattice_pkg::num_dirs; d++)
                begin
                    t = move_target(c, d);
                    if (mask[c] && t >= 0 && !mask[t])
                    begin
                        model_bank[nxt][d][t] = model_bank[nxt][reverse_dir(d)][c];
                    end
                end
            end
            for (int c = 0; c < cells; c++)
            begin
                for (int d = 0; d < lattice_pkg::num_dirs; d++)
                begin
                    if (mask[c])
                    begin
                        model_bank[nxt][d][c] = '0;
                    end
                end
            end
            model_cur = nxt;
        end
    endtask

    ////////////////////////////////////////////////////////////////////
    // Host access and runs

    task automatic load_grid();
        lattice_pkg::dist_t v;
        for (int c = 0; c < cells; c++)
        begin
            for (int d = 0; d < lattice_pkg::num_dirs; d++)
            begin
                draw_dist(v);
                model_bank[model_cur][d][c] = v;
                host_wr_en = 1'b1;
                host_addr  = lattice_pkg::cell_addr_t'(c);
                host_dir   = lattice_pkg::dir_t'(d);
                host_wdata = v;
                @(posedge clk);
                #1;
                host_wr_en = 1'b0;
            end
        end
    endtask

    // Back-to-back reads, data due one cycle after each request
    task automatic verify_grid();
        for (int c = 0; c < cells; c++)
        begin
            for (int d = 0; d < lattice_pkg::num_dirs; d++)
            begin
                host_rd_en = 1'b1;
                host_addr  = lattice_pkg::cell_addr_t'(c);
                host_dir   = lattice_pkg::dir_t'(d);
                @(posedge clk);
                #1;
                host_rd_en = 1'b0;
                check_flag("host_rvalid", host_rvalid, 1'b1);
                check_dist($sformatf("host_rdata cell %0d dir %0d", c, d),
                           host_rdata, model_bank[model_cur][d][c]);
            end
        end
        @(posedge clk);
        #1;
        check_flag("host_rvalid after reads", host_rvalid, 1'b0);
    endtask

    task automatic run_steps(control_pkg::step_count_t n);
        int expected;
        expected = int'(n) * step_cycles;
        steps    = n;
        start    = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;
        check_flag("busy after start", busy, 1'b1);
        for (int i = 1; i <= expected; i++)
        begin
            // Start again mid-run with another count, must be ignored
            if (i == 3)
            begin
                start = 1'b1;
                steps = 16'd7;
            end
            if (i == 4)
            begin
                start = 1'b0;
            end
            @(posedge clk);
            #1;
            check_flag($sformatf("done at cycle %0d", i), done, i == expected);
            check_flag($sformatf("busy at cycle %0d", i), busy, i != expected);
        end
        @(posedge clk);
        #1;
        check_flag("done one cycle after pulse", done, 1'b0);
    endtask

    initial
    begin
        rst        = 1'b0;
        start      = 1'b0;
        steps      = '0;
        barriers   = '0;
        host_wr_en = 1'b0;
        host_rd_en = 1'b0;
        host_addr  = '0;
        host_dir   = lattice_pkg::dir_rest;
        host_wdata = '0;
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b1;
        check_flag("busy after reset", busy, 1'b0);
        check_flag("done after reset", done, 1'b0);
        check_flag("host_rvalid after reset", host_rvalid, 1'b0);

        for (int r = 0; r < num_rows; r++)
        begin
            barriers = stim_table[r].mask;
            if (stim_table[r].load)
            begin
                load_grid();
                verify_grid();
            end
            run_steps(stim_table[r].steps);
            model_run(stim_table[r].mask, int'(stim_table[r].steps));
            verify_grid();
        end

        $display("Finished with no errors");
        $finish;
    end

    // Twice the cycles that the table needs
    initial
    begin
        int limit;
        limit = 16;
        for (int r = 0; r < num_rows; r++)
        begin
            limit += int'(stim_table[r].steps) * step_cycles + 2 * words + 8;
            if (stim_table[r].load)
            begin
                limit += 2 * words;
            end
        end
        repeat (2 * limit) @(posedge clk);
        $display("Watchdog expired, the run did not finish in time");
        $display("Finished with errors");
        $fatal(1, "timeout");
    end

endmodule

`default_nettype wire
